/* logic/noc_consts.svh */
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Descriptor word layout
`define P_RSVD      31
`define P_MEASURE   30
`define P_INJ       29:20
`define P_VC        19
`define P_SIZE      18:16
`define P_DEST      15:8
`define P_SRC       7:0

// Virtual channels and the width of a VC index
`define NUM_VCS     2
`define VC_W        1

// Size field is log2 of the flit count
`define MAX_LOG_SIZE 3

// Queue depths
`define DESC_DEPTH  4
`define FLIT_DEPTH  8

`endif

/* logic/noc_pkg.sv */
`include "noc_consts.svh"

package noc_pkg;

    typedef logic [7:0] node_addr_t;
    typedef logic [`VC_W-1:0] vc_id_t;

    // Matches the width of the P_SIZE field
    typedef logic [2:0] log_size_t;

    typedef logic [9:0] inj_time_t;

    // Decoded descriptor with the raw word kept for the head flit
    typedef struct packed {
        logic       measure;
        inj_time_t  inj_time;
        vc_id_t     vc;
        log_size_t  log_size;
        node_addr_t dest;
        node_addr_t src;
        logic [31:0] raw;
    } packet_desc_t;

    // One 35-bit flit on the output port
    typedef struct packed {
        logic        head;
        logic        tail;
        vc_id_t      vc;
        logic [31:0] data;
    } flit_t;

endpackage

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of queue is visible without a pop
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/packet_decode.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module packet_decode
    import noc_pkg::*;
#(
    parameter logic [7:0] HADDR = 8'h1B
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         enable,
    input  logic [31:0]  packet_in,
    input  logic         packet_in_valid,
    output logic         packet_request,
    output logic         desc_push,
    output packet_desc_t desc_data,
    input  logic         desc_full,
    output logic         busy,
    output logic         error
);

    logic [31:0] hold_word;
    logic        hold_valid;
    logic        accept;
    logic        bad_rsvd;
    logic        bad_size;
    logic        bad_dest;
    logic        hold_bad;

    // No new request while a descriptor sits in the decode register,
    // so the full flag already counts it when the next one arrives
    assign packet_request = enable && !desc_full && !hold_valid;
    assign accept         = packet_request && packet_in_valid;

    always_ff @(posedge clock)
    begin
        if (accept)
            hold_word <= packet_in;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            hold_valid <= 1'b0;
        else
            hold_valid <= accept;
    end

    // Validity rules
    assign bad_rsvd = hold_word[`P_RSVD];
    assign bad_size = (hold_word[`P_SIZE] > `MAX_LOG_SIZE);
    assign bad_dest = (hold_word[`P_DEST] == HADDR);
    assign hold_bad = bad_rsvd || bad_size || bad_dest;

    assign desc_push = hold_valid && !hold_bad;
    assign busy      = hold_valid;

    always_comb
    begin
        desc_data.measure  = hold_word[`P_MEASURE];
        desc_data.inj_time = hold_word[`P_INJ];
        desc_data.vc       = hold_word[`P_VC];
        desc_data.log_size = hold_word[`P_SIZE];
        desc_data.dest     = hold_word[`P_DEST];
        desc_data.src      = hold_word[`P_SRC];
        desc_data.raw      = hold_word;
    end

    // Sticky until reset
    always_ff @(posedge clock)
    begin
        if (reset)
            error <= 1'b0;
        else if (hold_valid && hold_bad)
            error <= 1'b1;
    end

endmodule

/* logic/flit_builder.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module flit_builder
    import noc_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    output logic                desc_pop,
    input  packet_desc_t        desc_data,
    input  logic                desc_empty,
    output logic [`NUM_VCS-1:0] flit_push,
    output flit_t               flit_data,
    input  logic [`NUM_VCS-1:0] flit_full,
    output logic                busy
);

    localparam int IDX_W = `MAX_LOG_SIZE + 1;

    typedef enum logic {
        S_IDLE,
        S_SEND
    } state_t;

    state_t       state;
    packet_desc_t cur;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] flit_total;
    logic         head_flit;
    logic         last_flit;
    logic         can_write;

    assign flit_total = IDX_W'(1) << cur.log_size;
    assign head_flit  = (idx == '0);
    assign last_flit  = (idx == flit_total - IDX_W'(1));

    // Stall while the target VC queue is full
    assign can_write = (state == S_SEND) && !flit_full[cur.vc];
    assign desc_pop  = (state == S_IDLE) && !desc_empty;
    assign busy      = (state == S_SEND);

    always_ff @(posedge clock)
    begin
        if (desc_pop)
            cur <= desc_data;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            idx   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    idx <= '0;
                    if (desc_pop)
                        state <= S_SEND;
                end
                S_SEND:
                begin
                    if (can_write)
                    begin
                        if (last_flit)
                        begin
                            state <= S_IDLE;
                            idx   <= '0;
                        end
                        else
                            idx <= idx + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb
    begin
        flit_data.head = head_flit;
        flit_data.tail = last_flit;
        flit_data.vc   = cur.vc;
        // Head carries the descriptor, the rest carry index and route
        if (head_flit)
            flit_data.data = cur.raw;
        else
            flit_data.data = {8'h00, 8'(idx), cur.dest, cur.src};

        flit_push = '0;
        if (can_write)
            flit_push[cur.vc] = 1'b1;
    end

endmodule

/* logic/vc_output_select.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module vc_output_select
    import noc_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  flit_t               vc_head [`NUM_VCS],
    input  logic [`NUM_VCS-1:0] vc_empty,
    output logic [`NUM_VCS-1:0] vc_pop,
    output flit_t               flit_out,
    output logic [`NUM_VCS-1:0] flit_out_valid,
    input  logic [`NUM_VCS-1:0] dequeue
);

    vc_id_t rr_ptr;
    vc_id_t sel_vc;
    logic   sel_valid;
    vc_id_t next_vc;
    logic   next_found;

    // Search starts just after the last VC served
    always_comb
    begin
        int cand;
        next_found = 1'b0;
        next_vc    = rr_ptr;
        for (int i = 1; i <= `NUM_VCS; i++)
        begin
            cand = (int'(rr_ptr) + i) % `NUM_VCS;
            if (!next_found && !vc_empty[cand])
            begin
                next_found = 1'b1;
                next_vc    = vc_id_t'(cand);
            end
        end
    end

    always_comb
    begin
        flit_out_valid = '0;
        if (sel_valid)
            flit_out_valid[sel_vc] = 1'b1;
    end

    assign flit_out = vc_head[sel_vc];

    // Only a dequeue on the shown VC pops
    assign vc_pop = dequeue & flit_out_valid;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            rr_ptr    <= vc_id_t'(`NUM_VCS - 1);
            sel_vc    <= '0;
            sel_valid <= 1'b0;
        end
        else if (sel_valid)
        begin
            if (|vc_pop)
            begin
                sel_valid <= 1'b0;
                rr_ptr    <= sel_vc;
            end
        end
        else if (next_found)
        begin
            sel_valid <= 1'b1;
            sel_vc    <= next_vc;
        end
    end

endmodule

/* logic/packet_player.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module packet_player
    import noc_pkg::*;
#(
    parameter logic [7:0] HADDR = 8'h1B
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  logic [31:0]         packet_in,
    input  logic                packet_in_valid,
    output logic                packet_request,
    output flit_t               flit_out,
    output logic [`NUM_VCS-1:0] flit_out_valid,
    input  logic [`NUM_VCS-1:0] dequeue,
    output logic                error,
    output logic                is_quiescent
);

    packet_desc_t        dec_desc;
    packet_desc_t        fifo_desc;
    logic                desc_push;
    logic                desc_pop;
    logic                desc_full;
    logic                desc_empty;
    logic                dec_busy;
    logic                bld_busy;

    flit_t               bld_flit;
    logic [`NUM_VCS-1:0] flit_push;
    logic [`NUM_VCS-1:0] flit_full;
    logic [`NUM_VCS-1:0] vc_empty;
    logic [`NUM_VCS-1:0] vc_pop;
    flit_t               vc_head [`NUM_VCS];

    packet_decode #(
        .HADDR (HADDR)
    ) u_decode (
        .clock           (clock),
        .reset           (reset),
        .enable          (enable),
        .packet_in       (packet_in),
        .packet_in_valid (packet_in_valid),
        .packet_request  (packet_request),
        .desc_push       (desc_push),
        .desc_data       (dec_desc),
        .desc_full       (desc_full),
        .busy            (dec_busy),
        .error           (error)
    );

    sync_fifo #(
        .payload_t (packet_desc_t),
        .DEPTH     (`DESC_DEPTH)
    ) u_desc_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (desc_push),
        .push_data (dec_desc),
        .pop       (desc_pop),
        .pop_data  (fifo_desc),
        .full      (desc_full),
        .empty     (desc_empty)
    );

    flit_builder u_builder (
        .clock      (clock),
        .reset      (reset),
        .desc_pop   (desc_pop),
        .desc_data  (fifo_desc),
        .desc_empty (desc_empty),
        .flit_push  (flit_push),
        .flit_data  (bld_flit),
        .flit_full  (flit_full),
        .busy       (bld_busy)
    );

    // One flit queue per VC
    for (genvar g = 0; g < `NUM_VCS; g++)
    begin : g_vc
        sync_fifo #(
            .payload_t (flit_t),
            .DEPTH     (`FLIT_DEPTH)
        ) u_vc_fifo (
            .clock     (clock),
            .reset     (reset),
            .push      (flit_push[g]),
            .push_data (bld_flit),
            .pop       (vc_pop[g]),
            .pop_data  (vc_head[g]),
            .full      (flit_full[g]),
            .empty     (vc_empty[g])
        );
    end

    vc_output_select u_select (
        .clock          (clock),
        .reset          (reset),
        .vc_head        (vc_head),
        .vc_empty       (vc_empty),
        .vc_pop         (vc_pop),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .dequeue        (dequeue)
    );

    assign is_quiescent = !dec_busy && !bld_busy && desc_empty && (&vc_empty);

endmodule

/* verif/packet_player_assert.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module packet_player_assert
    import noc_pkg::*;
(
    input logic                clock,
    input logic                reset,
    input logic                enable,
    input logic                packet_request,
    input flit_t               flit_out,
    input logic [`NUM_VCS-1:0] flit_out_valid,
    input logic [`NUM_VCS-1:0] dequeue,
    input logic                error,
    input logic                is_quiescent
);

    // At most one VC shown at a time
    a_valid_onehot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(flit_out_valid)
    ) else $error("flit_out_valid has more than one bit set");

    a_dequeue_on_valid: assert property (
        @(posedge clock) disable iff (reset) (dequeue & ~flit_out_valid) == '0
    ) else $error("dequeue raised on a VC that shows no flit");

    // Shown flit holds until the receiver takes it
    a_flit_stable: assert property (
        @(posedge clock) disable iff (reset)
        ((flit_out_valid != '0) && ((dequeue & flit_out_valid) == '0))
            |=> ($stable(flit_out) && $stable(flit_out_valid))
    ) else $error("flit_out changed before it was dequeued");

    a_quiet_after_reset: assert property (
        @(posedge clock) reset |=> ((flit_out_valid == '0) && !error && is_quiescent
                                    && (packet_request == enable))
    ) else $error("outputs not idle after reset");

endmodule

/* verif/packet_player_tb.sv */
`timescale 1ns/1ps
`include "noc_consts.svh"

module packet_player_tb
    import noc_pkg::*;
();

    localparam logic [7:0] HADDR     = 8'h1B;
    localparam int         NUM_FAST  = 40;
    localparam int         NUM_SLOW  = 20;
    localparam int         NUM_BAD   = 3;
    localparam int         NUM_DESC  = NUM_FAST + NUM_SLOW + 2 * NUM_BAD;
    localparam int         MAX_DELAY = 20;
    localparam int         WATCHDOG_CYCLES = NUM_DESC * 8 * (MAX_DELAY + 4) + 500;

    logic                clock;
    logic                reset;
    logic                enable;
    logic [31:0]         packet_in;
    logic                packet_in_valid;
    logic                packet_request;
    flit_t               flit_out;
    logic [`NUM_VCS-1:0] flit_out_valid;
    logic [`NUM_VCS-1:0] dequeue;
    logic                error;
    logic                is_quiescent;

    logic [31:0] rng;
    flit_t       exp_vc0 [$];
    flit_t       exp_vc1 [$];
    logic        exp_error;
    logic        slow_mode;
    int          req_low_run;
    int          max_req_low;

    packet_player #(
        .HADDR (HADDR)
    ) u_packet_player (
        .clock           (clock),
        .reset           (reset),
        .enable          (enable),
        .packet_in       (packet_in),
        .packet_in_valid (packet_in_valid),
        .packet_request  (packet_request),
        .flit_out        (flit_out),
        .flit_out_valid  (flit_out_valid),
        .dequeue         (dequeue),
        .error           (error),
        .is_quiescent    (is_quiescent)
    );

    bind packet_player packet_player_assert u_assert (
        .clock          (clock),
        .reset          (reset),
        .enable         (enable),
        .packet_request (packet_request),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .dequeue        (dequeue),
        .error          (error),
        .is_quiescent   (is_quiescent)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic desc_is_legal(input logic [31:0] desc);
        return !desc[`P_RSVD] && (desc[`P_SIZE] <= 3'(`MAX_LOG_SIZE)) && (desc[`P_DEST] != HADDR);
    endfunction

    // Expected flit number idx of the packet built from desc
    function automatic flit_t ref_flit(input logic [31:0] desc, input int idx);
        flit_t f;
        int    n;
        n      = 1 << desc[`P_SIZE];
        f.head = (idx == 0);
        f.tail = (idx == n - 1);
        f.vc   = desc[`P_VC];
        if (idx == 0)
            f.data = desc;
        else
            f.data = {8'h00, idx[7:0], desc[`P_DEST], desc[`P_SRC]};
        return f;
    endfunction

    function automatic logic [31:0] make_legal(input logic [31:0] r);
        logic [31:0] d;
        d          = r;
        d[`P_RSVD] = 1'b0;
        // Top size bit cleared keeps size within 0..3
        d[18]      = 1'b0;
        if (d[`P_DEST] == HADDR)
            d[`P_DEST] = ~HADDR;
        return d;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    // Expected flits are queued at the edge that accepts the descriptor
    task automatic model_accept(input logic [31:0] desc);
        int n;
        n = 1 << desc[`P_SIZE];
        if (!desc_is_legal(desc))
            exp_error = 1'b1;
        else
            for (int i = 0; i < n; i++)
            begin
                if (desc[`P_VC])
                    exp_vc1.push_back(ref_flit(desc, i));
                else
                    exp_vc0.push_back(ref_flit(desc, i));
            end
    endtask

    // Called and returns 5 ns after a rising edge
    task automatic send_desc(input logic [31:0] desc);
        logic taken;
        taken           = 1'b0;
        packet_in       = desc;
        packet_in_valid = 1'b1;
        while (!taken)
        begin
            @(negedge clock);
            taken = packet_request;
            @(posedge clock);
            #5;
        end
        packet_in_valid = 1'b0;
        model_accept(desc);
    endtask

    task automatic drain_and_check();
        while (exp_vc0.size() != 0 || exp_vc1.size() != 0)
            @(negedge clock);
        repeat (3) @(posedge clock);
        #5;
        check_value(64'(is_quiescent), 64'd1, "is_quiescent after drain");
        check_value(64'(error), 64'(exp_error), "sticky error flag");
    endtask

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial
    begin
        logic [31:0] d;
        rng             = 32'hb29c;
        reset           = 1'b1;
        enable          = 1'b0;
        packet_in       = '0;
        packet_in_valid = 1'b0;
        dequeue         = '0;
        slow_mode       = 1'b0;
        exp_error       = 1'b0;
        repeat (4) @(posedge clock);
        #5;
        reset = 1'b0;

        // Offered descriptor must not be taken while enable is low
        packet_in       = 32'h0001_2345;
        packet_in_valid = 1'b1;
        repeat (4)
        begin
            @(negedge clock);
            check_value(64'({packet_request, flit_out_valid, error, is_quiescent}),
                        64'({1'b0, 2'b00, 1'b0, 1'b1}), "outputs before enable");
        end
        @(posedge clock);
        #5;
        packet_in_valid = 1'b0;
        enable          = 1'b1;

        for (int i = 0; i < NUM_FAST; i++)
        begin
            rng = lcg_next(rng);
            send_desc(make_legal(rng));
        end
        drain_and_check();

        // Slow receiver backs up the whole pipe
        slow_mode   = 1'b1;
        max_req_low = 0;
        for (int i = 0; i < NUM_SLOW; i++)
        begin
            rng = lcg_next(rng);
            send_desc(make_legal(rng));
        end
        drain_and_check();
        if (max_req_low < 20)
            abort_run("packet_request never held off under back-pressure");

        slow_mode = 1'b0;
        for (int i = 0; i < NUM_BAD; i++)
        begin
            rng = lcg_next(rng);
            send_desc(make_legal(rng));
            rng = lcg_next(rng);
            d   = make_legal(rng);
            case (i)
                0:       d[`P_RSVD] = 1'b1;
                1:       d[`P_SIZE] = {1'b1, rng[21:20]};
                default: d[`P_DEST] = HADDR;
            endcase
            send_desc(d);
        end
        drain_and_check();

        $display("Result: PASSED");
        $finish;
    end

    // Receiver takes each flit after a random delay and compares it
    initial
    begin
        int    delay;
        flit_t expected;
        forever
        begin
            @(negedge clock);
            if (flit_out_valid != '0)
            begin
                rng = lcg_next(rng);
                if (slow_mode)
                    delay = 10 + int'(rng[31:16] % 16'd11);
                else
                    delay = int'(rng[31:16] % 16'd4);
                repeat (delay + 1) @(posedge clock);
                #5;
                if (flit_out_valid[1] ? (exp_vc1.size() == 0) : (exp_vc0.size() == 0))
                    abort_run("flit shown on a VC with no flit expected");
                else
                begin
                    if (flit_out_valid[1])
                        expected = exp_vc1.pop_front();
                    else
                        expected = exp_vc0.pop_front();
                    check_value(64'(flit_out), 64'(expected),
                                $sformatf("flit on VC%0d", flit_out_valid[1]));
                    dequeue = flit_out_valid;
                    @(posedge clock);
                    #5;
                    dequeue = '0;
                end
            end
        end
    end

    initial
    begin
        req_low_run = 0;
        max_req_low = 0;
        forever
        begin
            @(negedge clock);
            if (enable && !packet_request)
                req_low_run++;
            else
                req_low_run = 0;
            if (req_low_run > max_req_low)
                max_req_low = req_low_run;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run("watchdog expired before all packets drained");
    end

endmodule

/* vlog.f */
+incdir+logic
logic/noc_pkg.sv
logic/sync_fifo.sv
logic/packet_decode.sv
logic/flit_builder.sv
logic/vc_output_select.sv
logic/packet_player.sv
verif/packet_player_assert.sv
verif/packet_player_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := packet_player_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
